// ==== project.f ====
hdl/tsTimingPkg.sv
hdl/tsSwitchPkg.sv
hdl/tsModeSequencer.sv
hdl/tsPhaseCycler.sv
hdl/tsSwitchDriver.sv
hdl/tsDigTop.sv
testbench/tsDig_properties.sv
testbench/tsDigTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the temperature sensor controller testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert -f project.f --top-module tsDigTb -o tsDigSim

./obj_dir/tsDigSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification passed" sim.log; then
    exit 0
else
    exit 1
fi

// ==== testbench/tsDigTb.sv ====
`timescale 1ns/1ps

module tsDigTb;

    localparam int TEST_CYCLES = 3000;
    localparam int WATCHDOG_NS = 2 * TEST_CYCLES * 10;
    localparam logic [31:0] SEED = 32'hd27f;
    localparam int NUM_TESTS = 5;

    logic clk;
    logic reset;
    logic cmp;
    logic rst;
    logic pI1, pI2, pII1, pII2, pA, pB, pC, pD;
    logic bg2Cmp, capRst, preChrg;
    logic bgCtrl, ptatCtrl, rdisconN, setupBias;
    logic cmpP1, cmpP2, srcN, snk;

    logic [31:0] lfsr;
    logic        cmpAtEdge;
    int          errs [NUM_TESTS];
    string       testNames [NUM_TESTS];

    // Observation state of the comparison process.
    logic prevPreChrg, prevSetupBias, prevPI, prevPII, prevPI1, prevPII2, prevCmpP1;
    logic prevH, prevL, prevPD, winSetup;
    logic preDone, setupDone;
    int   preRun, bgLows, ptLows, hRun, lRun, lastCharge, hWins, lWins;
    int   winPulses, runWins, chopFlips, pII2Falls;

    tsDigTop dut (
        .clk(clk), .reset(reset), .cmp(cmp), .rst(rst),
        .pI1(pI1), .pI2(pI2), .pII1(pII1), .pII2(pII2),
        .pA(pA), .pB(pB), .pC(pC), .pD(pD),
        .bg2Cmp(bg2Cmp), .capRst(capRst), .preChrg(preChrg),
        .bgCtrl(bgCtrl), .ptatCtrl(ptatCtrl), .rdisconN(rdisconN), .setupBias(setupBias),
        .cmpP1(cmpP1), .cmpP2(cmpP2), .srcN(srcN), .snk(snk)
    );

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        lfsrNext = (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    // A high comparator sample asks for a source pulse, a low one for a sink pulse,
    // until the setup mode has seen its limit of low samples.
    function automatic logic [1:0] refTrim(input logic cmpBit, input int lowsSoFar);
        if (lowsSoFar >= tsTimingPkg::SETUP_LOW_LIMIT) begin
            refTrim = 2'b00;
        end else begin
            refTrim = {cmpBit, !cmpBit};
        end
    endfunction

    function automatic int refLowCount(input logic setupPhase);
        refLowCount = setupPhase ? tsTimingPkg::SETUP_LOW_LIMIT : 0;
    endfunction

    task automatic checkEqual(input string msg, input int got, input int exp, input int idx);
        if (got != exp) begin
            $display("ERR %0t: %s, got %0d expected %0d", $time, msg, got, exp);
            errs[idx] = errs[idx] + 1;
        end
    endtask

    task automatic noteFailure(input string msg, input int idx);
        $display("Test %s failed: %s", testNames[idx], msg);
        errs[idx] = errs[idx] + 1;
    endtask

    task automatic printTestLine(input int idx);
        if (errs[idx] == 0) begin
            $display("Test %s: ok", testNames[idx]);
        end else begin
            $display("Test %s: %0d errors", testNames[idx], errs[idx]);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = !clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the simulation did not finish within %0d ns", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

    always @(posedge clk) begin
        cmpAtEdge <= cmp;
    end

    always @(negedge clk) begin
        if (reset) begin
            checkEqual("idle switch bank", int'({pI1, pI2, pII1, pII2, pA, pB, pC, pD,
                       bg2Cmp, capRst, preChrg}), 2, 0);
            checkEqual("idle srcN snk cmpP1 cmpP2 rdisconN",
                       int'({srcN, snk, cmpP1, cmpP2, rdisconN}), 21, 0);
            checkEqual("idle rst bgCtrl ptatCtrl setupBias",
                       int'({rst, bgCtrl, ptatCtrl, setupBias}), 8, 0);
        end else if (!rst) begin
            if (preChrg) begin
                if (!prevPreChrg) begin
                    checkEqual("mode control at precharge start",
                               int'({bgCtrl, ptatCtrl, setupBias}), 5, 0);
                end
                preRun = preRun + 1;
            end else if (prevPreChrg && !preDone) begin
                checkEqual("precharge length", preRun, tsTimingPkg::PRECHARGE_CYCLES, 0);
                preDone = 1'b1;
                printTestLine(0);
            end

            if (preRun > 0 && !setupDone) begin
                checkEqual("ptatCtrl opposite bgCtrl", int'(ptatCtrl), int'(!bgCtrl), 1);
            end

            // Trim pulses in setup follow the comparator at the edge that made them.
            if (pI1 && setupBias) begin
                checkEqual("setup trim pulse", int'({!srcN, snk}),
                           int'(refTrim(cmpAtEdge, bgCtrl ? bgLows : ptLows)), 1);
            end
            if (!srcN || snk) begin
                checkEqual("trim pulse outside big-diode window", int'(pI1), 1, 4);
                if (pI1) begin
                    winPulses = winPulses + 1;
                end
            end
            if (snk && setupBias) begin
                if (bgCtrl) begin
                    bgLows = bgLows + 1;
                end else begin
                    ptLows = ptLows + 1;
                end
            end
            if (prevSetupBias && !setupBias && !setupDone) begin
                checkEqual("bandgap setup sink pulses", bgLows, refLowCount(1'b1), 1);
                checkEqual("PTAT setup sink pulses", ptLows, refLowCount(1'b1), 1);
                setupDone = 1'b1;
                printTestLine(1);
            end

            checkEqual("pI after pII without blank", int'((pI1 || pI2) && prevPII), 0, 2);
            checkEqual("pII after pI without blank", int'((pII1 || pII2) && prevPI), 0, 2);

            if (pA) begin
                checkEqual("bg2Cmp during charge", int'(bg2Cmp), 1, 3);
            end
            if (pA && pB) begin
                if (!prevH) begin
                    checkEqual("hCharge start order", lastCharge, 0, 3);
                end
                hRun = hRun + 1;
            end else if (prevH) begin
                checkEqual("hCharge length", hRun, tsTimingPkg::CHARGE_CYCLES, 3);
                hRun = 0;
                lastCharge = 1;
                hWins = hWins + 1;
            end
            if (pA && pC) begin
                if (!prevL) begin
                    checkEqual("lCharge start order", lastCharge, 1, 3);
                end
                lRun = lRun + 1;
            end else if (prevL) begin
                checkEqual("lCharge length", lRun, tsTimingPkg::CHARGE_CYCLES, 3);
                lRun = 0;
                lastCharge = 2;
                lWins = lWins + 1;
            end
            if (pD && !prevPD) begin
                checkEqual("output switches together", int'(pB && pC), 1, 3);
                if (!setupBias) begin
                    checkEqual("output after lCharge", lastCharge, 2, 3);
                end
                lastCharge = 0;
            end

            if (pI1 && !prevPI1) begin
                winSetup = setupBias;
                winPulses = (!srcN || snk) ? 1 : 0;
            end
            if (!pI1 && prevPI1 && !winSetup) begin
                checkEqual("trim pulses per run big-diode window", int'(winPulses <= 1), 1, 4);
                runWins = runWins + 1;
            end

            if (cmpP1 != prevCmpP1) begin
                chopFlips = chopFlips + 1;
                checkEqual("chopper flips ahead of diode window ends", chopFlips,
                           pII2Falls + 1, 4);
            end
            if (!pII2 && prevPII2) begin
                pII2Falls = pII2Falls + 1;
                checkEqual("chopper flips at diode window end", chopFlips, pII2Falls, 4);
            end
        end
        prevPreChrg   = preChrg;
        prevSetupBias = setupBias;
        prevPI        = pI1 || pI2;
        prevPII       = pII1 || pII2;
        prevPI1       = pI1;
        prevPII2      = pII2;
        prevCmpP1     = cmpP1;
        prevH         = pA && pB;
        prevL         = pA && pC;
        prevPD        = pD;
    end

    initial begin
        int total;
        testNames[0] = "reset";
        testNames[1] = "setup trim";
        testNames[2] = "window blanking";
        testNames[3] = "bandgap charge";
        testNames[4] = "chopper and run trim";
        for (int i = 0; i < NUM_TESTS; i++) begin
            errs[i] = 0;
        end
        preDone = 1'b0;
        setupDone = 1'b0;
        {prevPreChrg, prevSetupBias, prevPI, prevPII, prevPI1, prevPII2} = '0;
        {prevH, prevL, prevPD, winSetup} = '0;
        prevCmpP1 = 1'b1;
        {preRun, bgLows, ptLows, hRun, lRun, lastCharge, hWins, lWins} = '0;
        {winPulses, runWins, chopFlips, pII2Falls} = '0;
        lfsr = SEED;
        reset = 1'b1;
        cmp = 1'b0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        repeat (TEST_CYCLES) begin
            @(negedge clk);
            cmp = lfsr[0];
            lfsr = lfsrNext(lfsr);
        end
        @(posedge clk);
        #1;

        if (!preDone) begin
            noteFailure("the precharge window never ended", 0);
            printTestLine(0);
        end
        if (!setupDone) begin
            noteFailure("the setup modes never finished", 1);
            printTestLine(1);
        end
        if (hWins == 0 || lWins == 0) begin
            noteFailure("no bandgap charge windows were seen", 3);
        end
        if (runWins == 0 || chopFlips == 0) begin
            noteFailure("no run big-diode windows or chopper flips were seen", 4);
        end
        printTestLine(2);
        printTestLine(3);
        printTestLine(4);

        total = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            total = total + errs[i];
        end
        $display("Tests run: %0d, errors: %0d", NUM_TESTS, total);
        if (total == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== testbench/tsDig_properties.sv ====
`timescale 1ns/1ps

module tsDigProperties (
    input logic clk,
    input logic reset,
    input logic pI1,
    input logic pI2,
    input logic pII1,
    input logic pII2,
    input logic srcN,
    input logic snk,
    input logic cmpP1,
    input logic cmpP2
);

    // The big and small diode switches must never be closed at the same time.
    assert property (@(posedge clk) disable iff (reset)
        !((pI1 || pI2) && (pII1 || pII2)))
        else $error("pI and pII switches closed in the same cycle");

    assert property (@(posedge clk) disable iff (reset) !(!srcN && snk))
        else $error("source and sink trim pulses in the same cycle");

    assert property (@(posedge clk) cmpP1 != cmpP2)
        else $error("chopper pair not complementary");

endmodule

bind tsDigTop tsDigProperties props (
    .clk   (clk),
    .reset (reset),
    .pI1   (pI1),
    .pI2   (pI2),
    .pII1  (pII1),
    .pII2  (pII2),
    .srcN  (srcN),
    .snk   (snk),
    .cmpP1 (cmpP1),
    .cmpP2 (cmpP2)
);

// ==== hdl/tsDigTop.sv ====
`timescale 1ns/1ps

module tsDigTop (
    input  logic clk,
    input  logic reset,
    input  logic cmp,
    output logic rst,
    output logic pI1,
    output logic pI2,
    output logic pII1,
    output logic pII2,
    output logic pA,
    output logic pB,
    output logic pC,
    output logic pD,
    output logic bg2Cmp,
    output logic capRst,
    output logic preChrg,
    output logic bgCtrl,
    output logic ptatCtrl,
    output logic rdisconN,
    output logic setupBias,
    output logic cmpP1,
    output logic cmpP2,
    output logic srcN,
    output logic snk
);

    tsTimingPkg::modeT       mode;
    tsSwitchPkg::modeCtrlT   modeCtrl;
    tsSwitchPkg::trimT       trimReq;
    tsSwitchPkg::stepStatusT status;
    tsSwitchPkg::switchBankT switches;

    // rst stretches reset to the first clock edge after release.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rst <= 1'b1;
        end else begin
            rst <= 1'b0;
        end
    end

    tsModeSequencer sequencer (
        .clk      (clk),
        .reset    (reset),
        .rst      (rst),
        .cmp      (cmp),
        .status   (status),
        .mode     (mode),
        .modeCtrl (modeCtrl),
        .trimReq  (trimReq)
    );

    tsPhaseCycler cycler (
        .clk    (clk),
        .reset  (reset),
        .rst    (rst),
        .mode   (mode),
        .status (status)
    );

    tsSwitchDriver driver (
        .clk       (clk),
        .reset     (reset),
        .rst       (rst),
        .status    (status),
        .modeCtrl  (modeCtrl),
        .trimReq   (trimReq),
        .switches  (switches),
        .bgCtrl    (bgCtrl),
        .ptatCtrl  (ptatCtrl),
        .rdisconN  (rdisconN),
        .setupBias (setupBias),
        .cmpP1     (cmpP1),
        .cmpP2     (cmpP2),
        .srcN      (srcN),
        .snk       (snk)
    );

    assign pI1     = switches.pI1;
    assign pI2     = switches.pI2;
    assign pII1    = switches.pII1;
    assign pII2    = switches.pII2;
    assign pA      = switches.pA;
    assign pB      = switches.pB;
    assign pC      = switches.pC;
    assign pD      = switches.pD;
    assign bg2Cmp  = switches.bg2Cmp;
    assign capRst  = switches.capRst;
    assign preChrg = switches.preChrg;

endmodule

// ==== hdl/tsSwitchDriver.sv ====
`timescale 1ns/1ps

module tsSwitchDriver (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rst,
    input  tsSwitchPkg::stepStatusT status,
    input  tsSwitchPkg::modeCtrlT   modeCtrl,
    input  tsSwitchPkg::trimT       trimReq,
    output tsSwitchPkg::switchBankT switches,
    output logic                    bgCtrl,
    output logic                    ptatCtrl,
    output logic                    rdisconN,
    output logic                    setupBias,
    output logic                    cmpP1,
    output logic                    cmpP2,
    output logic                    srcN,
    output logic                    snk
);

    tsSwitchPkg::switchBankT bankNext;
    tsSwitchPkg::modeCtrlT   ctrlReg;

    // Blank windows leave every switch open.
    always_comb begin
        bankNext = '0;
        unique case (status.step)
            tsTimingPkg::precharge: begin
                bankNext.preChrg = 1'b1;
                bankNext.capRst  = 1'b1;
            end
            tsTimingPkg::diode: begin
                bankNext.pII1 = 1'b1;
                bankNext.pII2 = 1'b1;
            end
            tsTimingPkg::bigDiode: begin
                bankNext.pI1 = 1'b1;
                bankNext.pI2 = 1'b1;
            end
            tsTimingPkg::hCharge: begin
                bankNext.pA     = 1'b1;
                bankNext.pB     = 1'b1;
                bankNext.bg2Cmp = 1'b1;
            end
            tsTimingPkg::lCharge: begin
                bankNext.pA     = 1'b1;
                bankNext.pC     = 1'b1;
                bankNext.bg2Cmp = 1'b1;
            end
            tsTimingPkg::capOut: begin
                bankNext.pB = 1'b1;
                bankNext.pC = 1'b1;
                bankNext.pD = 1'b1;
            end
            tsTimingPkg::blankDiode, tsTimingPkg::blankBig:
                bankNext = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            switches <= tsSwitchPkg::SWITCH_IDLE;
            ctrlReg  <= tsSwitchPkg::MODE_CTRL_IDLE;
            cmpP1    <= 1'b1;
            cmpP2    <= 1'b0;
            srcN     <= 1'b1;
            snk      <= 1'b0;
        end else if (rst) begin
            switches <= tsSwitchPkg::SWITCH_IDLE;
            ctrlReg  <= tsSwitchPkg::MODE_CTRL_IDLE;
            cmpP1    <= 1'b1;
            cmpP2    <= 1'b0;
            srcN     <= 1'b1;
            snk      <= 1'b0;
        end else begin
            switches <= bankNext;
            ctrlReg  <= modeCtrl;
            if (status.chopToggle) begin
                cmpP1 <= !cmpP1;
                cmpP2 <= !cmpP2;
            end
            srcN <= !trimReq.src;
            snk  <= trimReq.snk;
        end
    end

    assign bgCtrl    = ctrlReg.bgCtrl;
    assign ptatCtrl  = ctrlReg.ptatCtrl;
    assign rdisconN  = ctrlReg.rdisconN;
    assign setupBias = ctrlReg.setupBias;

endmodule

// ==== hdl/tsPhaseCycler.sv ====
`timescale 1ns/1ps

module tsPhaseCycler (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rst,
    input  tsTimingPkg::modeT       mode,
    output tsSwitchPkg::stepStatusT status
);

    tsTimingPkg::stepT  step;
    tsTimingPkg::stepT  afterBlank;
    tsTimingPkg::stepT  nextStep;
    tsTimingPkg::modeT  winMode;
    tsTimingPkg::countT count;
    tsTimingPkg::countT winLen;
    logic               hCharged;
    logic               setupMode;
    logic               isBlank;
    logic               lastCycle;

    // winMode is the mode the current window runs under. It follows mode at each blank.
    assign setupMode = (winMode == tsTimingPkg::bgSetup) || (winMode == tsTimingPkg::ptatSetup);
    assign isBlank   = (step == tsTimingPkg::blankDiode) || (step == tsTimingPkg::blankBig);

    always_comb begin
        unique case (step)
            tsTimingPkg::precharge:
                winLen = tsTimingPkg::countT'(tsTimingPkg::PRECHARGE_CYCLES);
            tsTimingPkg::diode:
                winLen = setupMode ? tsTimingPkg::countT'(tsTimingPkg::SETUP_DIODE_CYCLES) :
                                     tsTimingPkg::countT'(tsTimingPkg::RUN_DIODE_CYCLES);
            tsTimingPkg::bigDiode:
                if (setupMode) begin
                    winLen = tsTimingPkg::countT'(tsTimingPkg::SETUP_BIG_CYCLES);
                end else if (winMode == tsTimingPkg::bandgap) begin
                    winLen = tsTimingPkg::countT'(tsTimingPkg::BG_BIG_CYCLES);
                end else begin
                    winLen = tsTimingPkg::countT'(tsTimingPkg::PTAT_BIG_CYCLES);
                end
            tsTimingPkg::hCharge, tsTimingPkg::lCharge:
                winLen = tsTimingPkg::countT'(tsTimingPkg::CHARGE_CYCLES);
            tsTimingPkg::capOut:
                // One cycle per round in bandgap mode, a long window when closing setup.
                winLen = (winMode == tsTimingPkg::bandgap) ? tsTimingPkg::countT'(1) :
                         tsTimingPkg::countT'(tsTimingPkg::SETUP_OUTPUT_CYCLES);
            tsTimingPkg::blankDiode, tsTimingPkg::blankBig:
                winLen = tsTimingPkg::countT'(1);
        endcase
    end

    assign lastCycle = (count == winLen - tsTimingPkg::countT'(1));

    // Bandgap rounds run big diode, diode, hCharge, then big diode, diode, lCharge, capOut.
    always_comb begin
        unique case (step)
            tsTimingPkg::bigDiode:
                nextStep = tsTimingPkg::diode;
            tsTimingPkg::diode:
                if (winMode == tsTimingPkg::bandgap) begin
                    nextStep = hCharged ? tsTimingPkg::lCharge : tsTimingPkg::hCharge;
                end else begin
                    nextStep = tsTimingPkg::bigDiode;
                end
            tsTimingPkg::lCharge:
                nextStep = tsTimingPkg::capOut;
            tsTimingPkg::precharge, tsTimingPkg::hCharge, tsTimingPkg::capOut,
            tsTimingPkg::blankDiode, tsTimingPkg::blankBig:
                nextStep = tsTimingPkg::bigDiode;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step       <= tsTimingPkg::precharge;
            afterBlank <= tsTimingPkg::bigDiode;
            winMode    <= tsTimingPkg::bgSetup;
            count      <= '0;
            hCharged   <= 1'b0;
        end else if (rst) begin
            step       <= tsTimingPkg::precharge;
            afterBlank <= tsTimingPkg::bigDiode;
            winMode    <= tsTimingPkg::bgSetup;
            count      <= '0;
            hCharged   <= 1'b0;
        end else if (!lastCycle) begin
            count <= count + tsTimingPkg::countT'(1);
        end else begin
            count <= '0;
            if (isBlank) begin
                winMode <= mode;
                // A new mode starts fresh; leaving bandgap setup passes through capOut first.
                if (mode != winMode) begin
                    step <= (winMode == tsTimingPkg::bgSetup) ? tsTimingPkg::capOut :
                                                                tsTimingPkg::bigDiode;
                end else begin
                    step <= afterBlank;
                end
            end else begin
                afterBlank <= nextStep;
                step <= (nextStep == tsTimingPkg::diode) ? tsTimingPkg::blankDiode :
                                                           tsTimingPkg::blankBig;
                if (step == tsTimingPkg::hCharge) begin
                    hCharged <= 1'b1;
                end
                if (step == tsTimingPkg::capOut) begin
                    hCharged <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        status.step       = step;
        status.mode       = winMode;
        status.stepFirst  = (count == '0);
        status.stepLast   = lastCycle;
        status.chopToggle = lastCycle && (step == tsTimingPkg::diode);
    end

endmodule

// ==== hdl/tsModeSequencer.sv ====
`timescale 1ns/1ps

module tsModeSequencer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rst,
    input  logic                    cmp,
    input  tsSwitchPkg::stepStatusT status,
    output tsTimingPkg::modeT       mode,
    output tsSwitchPkg::modeCtrlT   modeCtrl,
    output tsSwitchPkg::trimT       trimReq
);

    logic [2:0]         lowCount;
    logic               intermCmp;
    tsTimingPkg::countT roundCount;
    tsTimingPkg::modeT  nextMode;
    logic               setupMode;
    logic               inBig;
    logic               lowHit;
    logic               roundStep;
    logic               latchCmp;

    // Trim decisions follow the mode of the window the cycler is running.
    assign setupMode = (status.mode == tsTimingPkg::bgSetup) ||
                       (status.mode == tsTimingPkg::ptatSetup);
    assign inBig     = (status.step == tsTimingPkg::bigDiode);

    // Setup samples cmp on every big-diode cycle until the low limit is reached.
    // Run modes trim once, from the value held since the last charge or blank window.
    always_comb begin
        trimReq = '0;
        if (inBig) begin
            if (setupMode) begin
                if (lowCount < 3'(tsTimingPkg::SETUP_LOW_LIMIT)) begin
                    trimReq.src = cmp;
                    trimReq.snk = !cmp;
                end
            end else if (status.stepFirst) begin
                trimReq.src = intermCmp;
                trimReq.snk = !intermCmp;
            end
        end
    end

    assign lowHit = setupMode &&
                    ((lowCount == 3'(tsTimingPkg::SETUP_LOW_LIMIT)) ||
                     (trimReq.snk && lowCount == 3'(tsTimingPkg::SETUP_LOW_LIMIT - 1)));

    assign roundStep = status.stepLast &&
                       ((mode == tsTimingPkg::bandgap && status.step == tsTimingPkg::capOut) ||
                        (mode == tsTimingPkg::ptat && status.step == tsTimingPkg::diode));

    assign latchCmp = status.stepLast &&
                      ((status.step == tsTimingPkg::hCharge) ||
                       (status.step == tsTimingPkg::lCharge) ||
                       (mode == tsTimingPkg::ptat &&
                        (status.step == tsTimingPkg::blankDiode ||
                         status.step == tsTimingPkg::blankBig)));

    always_comb begin
        nextMode = mode;
        if (status.stepLast) begin
            unique case (mode)
                tsTimingPkg::bgSetup:
                    if (inBig && lowHit) nextMode = tsTimingPkg::ptatSetup;
                tsTimingPkg::ptatSetup:
                    if (inBig && lowHit) nextMode = tsTimingPkg::bandgap;
                tsTimingPkg::bandgap:
                    if (roundStep && roundCount ==
                        tsTimingPkg::countT'(tsTimingPkg::BG_OUTPUT_ROUNDS - 1)) begin
                        nextMode = tsTimingPkg::ptat;
                    end
                tsTimingPkg::ptat:
                    if (roundStep && roundCount ==
                        tsTimingPkg::countT'(tsTimingPkg::PTAT_ROUNDS - 1)) begin
                        nextMode = tsTimingPkg::bandgap;
                    end
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mode       <= tsTimingPkg::bgSetup;
            lowCount   <= '0;
            roundCount <= '0;
            intermCmp  <= 1'b0;
        end else if (rst) begin
            mode       <= tsTimingPkg::bgSetup;
            lowCount   <= '0;
            roundCount <= '0;
            intermCmp  <= 1'b0;
        end else begin
            if (latchCmp) begin
                intermCmp <= cmp;
            end
            if (nextMode != mode) begin
                mode       <= nextMode;
                lowCount   <= '0;
                roundCount <= '0;
            end else begin
                if (setupMode && trimReq.snk) begin
                    lowCount <= lowCount + 3'd1;
                end
                if (roundStep) begin
                    roundCount <= roundCount + tsTimingPkg::countT'(1);
                end
            end
        end
    end

    always_comb begin
        unique case (mode)
            tsTimingPkg::bgSetup:   modeCtrl = '{bgCtrl: 1'b1, ptatCtrl: 1'b0,
                                                rdisconN: 1'b1, setupBias: 1'b1};
            tsTimingPkg::ptatSetup: modeCtrl = '{bgCtrl: 1'b0, ptatCtrl: 1'b1,
                                                rdisconN: 1'b0, setupBias: 1'b1};
            tsTimingPkg::bandgap:   modeCtrl = '{bgCtrl: 1'b1, ptatCtrl: 1'b0,
                                                rdisconN: 1'b1, setupBias: 1'b0};
            tsTimingPkg::ptat:      modeCtrl = '{bgCtrl: 1'b0, ptatCtrl: 1'b1,
                                                rdisconN: 1'b0, setupBias: 1'b0};
        endcase
    end

endmodule

// ==== hdl/tsSwitchPkg.sv ====
package tsSwitchPkg;

    // Window status from the phase cycler.
    typedef struct packed {
        tsTimingPkg::stepT step;
        tsTimingPkg::modeT mode;
        logic              stepFirst;
        logic              stepLast;
        logic              chopToggle;
    } stepStatusT;

    typedef struct packed {
        logic bgCtrl;
        logic ptatCtrl;
        logic rdisconN;
        logic setupBias;
    } modeCtrlT;

    typedef struct packed {
        logic pI1;
        logic pI2;
        logic pII1;
        logic pII2;
        logic pA;
        logic pB;
        logic pC;
        logic pD;
        logic bg2Cmp;
        logic capRst;
        logic preChrg;
    } switchBankT;

    typedef struct packed {
        logic src;
        logic snk;
    } trimT;

    // Idle levels of the analog side while the controller is in reset.
    localparam switchBankT SWITCH_IDLE = '{capRst: 1'b1, default: 1'b0};
    localparam modeCtrlT MODE_CTRL_IDLE = '{rdisconN: 1'b1, default: 1'b0};

endpackage

// ==== hdl/tsTimingPkg.sv ====
package tsTimingPkg;

    // Operating modes, visited in this order after the two setup modes.
    typedef enum logic [1:0] {
        bgSetup,
        ptatSetup,
        bandgap,
        ptat
    } modeT;

    // Switch windows. capOut is the capacitor output window.
    typedef enum logic [2:0] {
        precharge,
        blankDiode,
        diode,
        blankBig,
        bigDiode,
        hCharge,
        lCharge,
        capOut
    } stepT;

    typedef logic [5:0] countT;

    // Window lengths in clock cycles.
    localparam int PRECHARGE_CYCLES    = 17;
    localparam int SETUP_DIODE_CYCLES  = 3;
    localparam int SETUP_BIG_CYCLES    = 7;
    localparam int RUN_DIODE_CYCLES    = 9;
    localparam int BG_BIG_CYCLES       = 12;
    localparam int PTAT_BIG_CYCLES     = 27;
    localparam int CHARGE_CYCLES       = 6;
    localparam int SETUP_OUTPUT_CYCLES = 17;

    // Loop limits.
    localparam int SETUP_LOW_LIMIT  = 5;
    localparam int BG_OUTPUT_ROUNDS = 7;
    localparam int PTAT_ROUNDS      = 16;

endpackage
